// ==== source/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and byte address width
`define CPU_XLEN 32

// Register file shape
`define CPU_REG_AW 5
`define CPU_NREGS 32

// Fetch port carries a word address
`define CPU_IADDR_W 14

`define CPU_PC_STEP 4
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== source/isa_pkg.sv ====
`include "cpu_params.svh"

package isa_pkg;

    // Three-register format
    typedef struct packed {
        logic [16:0]            opcode;
        logic [`CPU_REG_AW-1:0] rk;
        logic [`CPU_REG_AW-1:0] rj;
        logic [`CPU_REG_AW-1:0] rd;
    } inst_3r_t;

    // Two registers and a 12-bit immediate
    typedef struct packed {
        logic [9:0]             opcode;
        logic [11:0]            imm;
        logic [`CPU_REG_AW-1:0] rj;
        logic [`CPU_REG_AW-1:0] rd;
    } inst_2ri12_t;

    // One register and a 20-bit immediate
    typedef struct packed {
        logic [6:0]             opcode;
        logic [19:0]            imm;
        logic [`CPU_REG_AW-1:0] rd;
    } inst_1ri20_t;

    typedef union packed {
        inst_3r_t    r3;
        inst_2ri12_t ri12;
        inst_1ri20_t ri20;
    } inst_t;

    // LA32R opcode fields
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_and = 17'h00029;
    localparam logic [16:0] op_or = 17'h0002a;

    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_b = 10'h0a0;
    localparam logic [9:0] op_ld_w = 10'h0a2;
    localparam logic [9:0] op_st_b = 10'h0a4;
    localparam logic [9:0] op_st_w = 10'h0a6;
    localparam logic [9:0] op_ld_bu = 10'h0a8;

    localparam logic [6:0] op_lu12i_w = 7'h0a;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_e;

endpackage

// ==== source/pipe_pkg.sv ====
`include "cpu_params.svh"

package pipe_pkg;

    typedef struct packed {
        logic             rf_we;
        isa_pkg::alu_op_e alu_op;
        logic             use_imm;
        logic             mem_re;
        logic             mem_we;
        logic             mem_byte;
        logic             load_signed;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   op_a;
        logic [`CPU_XLEN-1:0]   op_b;
        logic [`CPU_XLEN-1:0]   imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   alu_res;
        logic [`CPU_XLEN-1:0]   st_data;
    } ex_mem_t;

    // Result a later stage is about to write back
    typedef struct packed {
        logic                   we;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   value;
    } fwd_t;

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file (
    input  logic                   cpu_clk,
    input  logic [`CPU_REG_AW-1:0] raddr1,
    input  logic [`CPU_REG_AW-1:0] raddr2,
    output logic [`CPU_XLEN-1:0]   rdata1,
    output logic [`CPU_XLEN-1:0]   rdata2,
    input  logic                   we,
    input  logic [`CPU_REG_AW-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]   wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge cpu_clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module decode_stage (
    input  logic                    cpu_clk,
    input  logic                    cpu_rst,
    input  logic [31:0]             inst,
    output logic [`CPU_IADDR_W-1:0] inst_addr,
    input  pipe_pkg::fwd_t          ex_fwd,
    input  pipe_pkg::fwd_t          mem_fwd,
    input  pipe_pkg::fwd_t          wb_fwd,
    input  logic                    ex_is_load,
    output pipe_pkg::id_ex_t        id_ex
);

    logic [`CPU_XLEN-1:0]   pc;
    isa_pkg::inst_t         if_id_inst;
    pipe_pkg::ctrl_t        ctrl;
    pipe_pkg::id_ex_t       id_ex_next;
    logic [`CPU_XLEN-1:0]   imm;
    logic [`CPU_REG_AW-1:0] r2_addr;
    logic                   use_rj;
    logic                   use_r2;
    logic                   stall;
    logic [`CPU_XLEN-1:0]   rf_rdata1;
    logic [`CPU_XLEN-1:0]   rf_rdata2;

    // Youngest producer wins
    function automatic logic [`CPU_XLEN-1:0] pick_operand(
        input logic [`CPU_REG_AW-1:0] ra,
        input logic [`CPU_XLEN-1:0]   rf_val
    );
        logic [`CPU_XLEN-1:0] val;
        val = rf_val;
        if (ra != '0) begin
            if (ex_fwd.we && ex_fwd.rd == ra)
                val = ex_fwd.value;
            else if (mem_fwd.we && mem_fwd.rd == ra)
                val = mem_fwd.value;
            else if (wb_fwd.we && wb_fwd.rd == ra)
                val = wb_fwd.value;
        end
        return val;
    endfunction

    assign inst_addr = pc[`CPU_IADDR_W+1:2];

    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            pc <= `CPU_RESET_PC;
            if_id_inst <= '0;
        end else if (!stall) begin
            pc <= pc + `CPU_PC_STEP;
            if_id_inst <= inst;
        end
    end

    reg_file u_reg_file (
        .cpu_clk (cpu_clk),
        .raddr1  (if_id_inst.r3.rj),
        .raddr2  (r2_addr),
        .rdata1  (rf_rdata1),
        .rdata2  (rf_rdata2),
        .we      (wb_fwd.we),
        .waddr   (wb_fwd.rd),
        .wdata   (wb_fwd.value)
    );

    always_comb begin
        ctrl = '0;
        use_rj = 1'b0;
        use_r2 = 1'b0;
        r2_addr = if_id_inst.r3.rk;
        imm = {{(`CPU_XLEN-12){if_id_inst.ri12.imm[11]}}, if_id_inst.ri12.imm};
        case (if_id_inst.r3.opcode)
            isa_pkg::op_add_w,
            isa_pkg::op_sub_w,
            isa_pkg::op_and,
            isa_pkg::op_or: begin
                ctrl.rf_we = 1'b1;
                use_rj = 1'b1;
                use_r2 = 1'b1;
            end
            default: ;
        endcase
        case (if_id_inst.r3.opcode)
            isa_pkg::op_sub_w: ctrl.alu_op = isa_pkg::alu_sub;
            isa_pkg::op_and:   ctrl.alu_op = isa_pkg::alu_and;
            isa_pkg::op_or:    ctrl.alu_op = isa_pkg::alu_or;
            default: ;
        endcase
        case (if_id_inst.ri12.opcode)
            isa_pkg::op_addi_w,
            isa_pkg::op_ld_w,
            isa_pkg::op_ld_b,
            isa_pkg::op_ld_bu: begin
                ctrl.rf_we = 1'b1;
                ctrl.use_imm = 1'b1;
                use_rj = 1'b1;
                ctrl.mem_re = (if_id_inst.ri12.opcode != isa_pkg::op_addi_w);
                ctrl.mem_byte = (if_id_inst.ri12.opcode == isa_pkg::op_ld_b) ||
                                (if_id_inst.ri12.opcode == isa_pkg::op_ld_bu);
                ctrl.load_signed = (if_id_inst.ri12.opcode == isa_pkg::op_ld_b);
            end
            isa_pkg::op_st_w,
            isa_pkg::op_st_b: begin
                // Store data comes from rd
                ctrl.use_imm = 1'b1;
                ctrl.mem_we = 1'b1;
                ctrl.mem_byte = (if_id_inst.ri12.opcode == isa_pkg::op_st_b);
                use_rj = 1'b1;
                use_r2 = 1'b1;
                r2_addr = if_id_inst.ri12.rd;
            end
            default: ;
        endcase
        if (if_id_inst.ri20.opcode == isa_pkg::op_lu12i_w) begin
            ctrl.rf_we = 1'b1;
            ctrl.use_imm = 1'b1;
            imm = {if_id_inst.ri20.imm, 12'h000};
        end
    end

    // Load result not ready until MEM
    assign stall = ex_is_load && ex_fwd.rd != '0 &&
                   ((use_rj && if_id_inst.r3.rj == ex_fwd.rd) ||
                    (use_r2 && r2_addr == ex_fwd.rd));

    always_comb begin
        id_ex_next.ctrl = ctrl;
        id_ex_next.rd = if_id_inst.r3.rd;
        id_ex_next.op_a = use_rj ? pick_operand(if_id_inst.r3.rj, rf_rdata1) : '0;
        id_ex_next.op_b = pick_operand(r2_addr, rf_rdata2);
        id_ex_next.imm = imm;
    end

    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            id_ex <= '0;
        end else if (stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module execute_stage (
    input  logic              cpu_clk,
    input  logic              cpu_rst,
    input  pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::fwd_t    ex_fwd,
    output logic              ex_is_load
);

    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] alu_res;

    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            isa_pkg::alu_add: alu_res = id_ex.op_a + alu_b;
            isa_pkg::alu_sub: alu_res = id_ex.op_a - alu_b;
            isa_pkg::alu_and: alu_res = id_ex.op_a & alu_b;
            isa_pkg::alu_or:  alu_res = id_ex.op_a | alu_b;
            default:          alu_res = id_ex.op_a + alu_b;
        endcase
    end

    // A load only has its address here
    always_comb begin
        ex_fwd.we = id_ex.ctrl.rf_we && !id_ex.ctrl.mem_re;
        ex_fwd.rd = id_ex.rd;
        ex_fwd.value = alu_res;
    end

    assign ex_is_load = id_ex.ctrl.mem_re;

    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
            ex_mem.rd <= id_ex.rd;
            ex_mem.alu_res <= alu_res;
            ex_mem.st_data <= id_ex.op_b;
        end
    end

endmodule

// ==== source/result_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module result_stage (
    input  logic                 cpu_clk,
    input  logic                 cpu_rst,
    input  pipe_pkg::ex_mem_t    ex_mem,
    input  logic [`CPU_XLEN-1:0] bus_rdata,
    output logic [`CPU_XLEN-1:0] bus_addr,
    output logic                 bus_we,
    output logic [`CPU_XLEN-1:0] bus_wdata,
    output pipe_pkg::fwd_t       mem_fwd,
    output pipe_pkg::fwd_t       wb_fwd
);

    logic [1:0]           byte_off;
    logic [7:0]           load_byte;
    logic [`CPU_XLEN-1:0] load_val;

    assign bus_addr = ex_mem.alu_res;
    assign bus_we = ex_mem.ctrl.mem_we;
    assign byte_off = ex_mem.alu_res[1:0];

    // Byte store rewrites one lane of the word just read
    always_comb begin
        bus_wdata = ex_mem.st_data;
        if (ex_mem.ctrl.mem_byte) begin
            bus_wdata = bus_rdata;
            bus_wdata[{byte_off, 3'b000} +: 8] = ex_mem.st_data[7:0];
        end
    end

    assign load_byte = bus_rdata[{byte_off, 3'b000} +: 8];

    always_comb begin
        if (!ex_mem.ctrl.mem_byte)
            load_val = bus_rdata;
        else if (ex_mem.ctrl.load_signed)
            load_val = {{(`CPU_XLEN-8){load_byte[7]}}, load_byte};
        else
            load_val = {{(`CPU_XLEN-8){1'b0}}, load_byte};
    end

    always_comb begin
        mem_fwd.we = ex_mem.ctrl.rf_we;
        mem_fwd.rd = ex_mem.rd;
        mem_fwd.value = ex_mem.ctrl.mem_re ? load_val : ex_mem.alu_res;
    end

    // MEM/WB register
    always_ff @(posedge cpu_clk or posedge cpu_rst) begin
        if (cpu_rst) begin
            wb_fwd <= '0;
        end else begin
            wb_fwd <= mem_fwd;
        end
    end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
    input  logic                    cpu_clk,
    input  logic                    cpu_rst,
    output logic [`CPU_IADDR_W-1:0] inst_addr,
    input  logic [31:0]             inst,
    output logic [`CPU_XLEN-1:0]    bus_addr,
    output logic                    bus_we,
    output logic [`CPU_XLEN-1:0]    bus_wdata,
    input  logic [`CPU_XLEN-1:0]    bus_rdata
);

    pipe_pkg::id_ex_t  id_ex;
    pipe_pkg::ex_mem_t ex_mem;
    pipe_pkg::fwd_t    ex_fwd;
    pipe_pkg::fwd_t    mem_fwd;
    pipe_pkg::fwd_t    wb_fwd;
    logic              ex_is_load;

    decode_stage u_decode (
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .inst       (inst),
        .inst_addr  (inst_addr),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .id_ex      (id_ex)
    );

    execute_stage u_execute (
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .ex_fwd     (ex_fwd),
        .ex_is_load (ex_is_load)
    );

    result_stage u_result (
        .cpu_clk   (cpu_clk),
        .cpu_rst   (cpu_rst),
        .ex_mem    (ex_mem),
        .bus_rdata (bus_rdata),
        .bus_addr  (bus_addr),
        .bus_we    (bus_we),
        .bus_wdata (bus_wdata),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_ns = 10
) (
    output logic cpu_clk
);

    initial begin
        cpu_clk = 1'b0;
    end

    // 20 ns period
    always #(half_ns) cpu_clk = ~cpu_clk;

endmodule

// ==== tests/cpu_asserts.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_asserts (
    input logic                    cpu_clk,
    input logic                    cpu_rst,
    input logic [`CPU_IADDR_W-1:0] inst_addr,
    input logic                    bus_we,
    input logic [`CPU_XLEN-1:0]    bus_addr,
    input logic [`CPU_XLEN-1:0]    bus_wdata
);

    // Stage registers hold bubbles while in reset
    no_store_in_reset: assert property (@(posedge cpu_clk) cpu_rst |-> !bus_we)
        else $error("bus_we is high while cpu_rst is asserted");

    // No branches, so fetch either holds on a stall or steps one word
    fetch_step: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        (inst_addr == $past(inst_addr)) || (inst_addr == $past(inst_addr) + 14'd1))
        else $error("inst_addr moved by more than one word");

    bus_known: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
        bus_we |-> !$isunknown({bus_addr, bus_wdata}))
        else $error("unknown address or data on a bus write");

endmodule

bind cpu_top cpu_asserts u_asserts (
    .cpu_clk   (cpu_clk),
    .cpu_rst   (cpu_rst),
    .inst_addr (inst_addr),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata)
);

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;

    localparam logic [31:0] done_addr = 32'h0000_03fc;
    localparam logic [31:0] done_mark = 32'h0000_06d1;
    localparam int          prog_max = 256;

    // LA32R opcode fields
    localparam logic [16:0] add_w = 17'h00020;
    localparam logic [16:0] sub_w = 17'h00022;
    localparam logic [16:0] and_op = 17'h00029;
    localparam logic [16:0] or_op = 17'h0002a;
    localparam logic [9:0]  addi_w = 10'h00a;
    localparam logic [9:0]  ld_b = 10'h0a0;
    localparam logic [9:0]  ld_w = 10'h0a2;
    localparam logic [9:0]  st_b = 10'h0a4;
    localparam logic [9:0]  st_w = 10'h0a6;
    localparam logic [9:0]  ld_bu = 10'h0a8;
    localparam logic [6:0]  lu12i_w = 7'h0a;
    localparam logic [16:0] alu_codes [4] = '{add_w, sub_w, and_op, or_op};

    // Result slots are word addressed from 0x100, held in r29
    localparam logic [4:0] base_reg = 5'd29;

    logic                    cpu_clk;
    logic                    cpu_rst;
    logic [`CPU_IADDR_W-1:0] inst_addr;
    logic [31:0]             inst;
    logic [`CPU_XLEN-1:0]    bus_addr;
    logic                    bus_we;
    logic [`CPU_XLEN-1:0]    bus_wdata;
    logic [`CPU_XLEN-1:0]    bus_rdata;

    logic [31:0] imem [prog_max] = '{default: 32'h0};
    logic [31:0] dmem [256] = '{default: 32'h0};
    logic        mem_load;
    logic [31:0] prog [$];
    logic [7:0]  exp_idx [$];
    logic [31:0] exp_val [$];
    logic [31:0] lcg_state = 32'h37ddff34;
    int          cycle_budget = 20;
    int          watch_cycles = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tb_clock clk_gen (
        .cpu_clk (cpu_clk)
    );

    cpu_top dut0 (
        .cpu_clk   (cpu_clk),
        .cpu_rst   (cpu_rst),
        .inst_addr (inst_addr),
        .inst      (inst),
        .bus_addr  (bus_addr),
        .bus_we    (bus_we),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata)
    );

    // Both memories answer in the same cycle
    assign inst = (inst_addr[`CPU_IADDR_W-1:8] == '0) ? imem[inst_addr[7:0]] : 32'h0;
    assign bus_rdata = dmem[bus_addr[9:2]];

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'ha5, ~idx, idx + 8'h3d, idx};
    endfunction

    always @(posedge cpu_clk) begin
        if (mem_load) begin
            for (int k = 0; k < prog_max; k++) begin
                imem[k[7:0]] <= (k < prog.size()) ? prog[k] : 32'h0;
                dmem[k[7:0]] <= fill_word(k[7:0]);
            end
        end else if (bus_we) begin
            dmem[bus_addr[9:2]] <= bus_wdata;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic put_3r(input logic [16:0] op, input logic [4:0] rd, rj, rk);
        prog.push_back({op, rk, rj, rd});
    endtask

    task automatic put_2ri12(input logic [9:0] op, input logic [4:0] rd, rj,
                             input logic [11:0] imm);
        prog.push_back({op, imm, rj, rd});
    endtask

    // addi sign-extends, so the upper part absorbs bit 11
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = value[31:12] + {19'd0, value[11]};
        prog.push_back({lu12i_w, hi, rd});
        put_2ri12(addi_w, rd, rd, value[11:0]);
    endtask

    task automatic pad(input int count);
        for (int n = 0; n < count; n++) begin
            put_2ri12(addi_w, 5'd10, 5'd0, 12'h001);
        end
    endtask

    function automatic logic [11:0] slot_off(input logic [7:0] slot);
        return {2'b00, slot, 2'b00};
    endfunction

    task automatic expect_word(input logic [7:0] idx, input logic [31:0] value);
        exp_idx.push_back(idx);
        exp_val.push_back(value);
    endtask

    task automatic store_expect(input logic [4:0] rs, input logic [7:0] slot,
                                input logic [31:0] value);
        put_2ri12(st_w, rs, base_reg, slot_off(slot));
        expect_word(8'd64 + slot, value);
    endtask

    function automatic logic [31:0] alu_expect(input logic [16:0] op,
                                               input logic [31:0] a, b);
        if (op == add_w)
            return a + b;
        if (op == sub_w)
            return a - b;
        if (op == and_op)
            return a & b;
        return a | b;
    endfunction

    // Appends the done store, resets the DUT and waits for that store
    task automatic run_program();
        put_2ri12(addi_w, 5'd31, 5'd0, done_mark[11:0]);
        put_2ri12(addi_w, 5'd30, 5'd0, done_addr[11:0]);
        put_2ri12(st_w, 5'd31, 5'd30, 12'h000);
        cycle_budget += prog.size() * 10 + 16;
        @(posedge cpu_clk);
        cpu_rst <= 1'b1;
        mem_load <= 1'b1;
        @(posedge cpu_clk);
        mem_load <= 1'b0;
        repeat (7) @(posedge cpu_clk);
        cpu_rst <= 1'b0;
        @(posedge cpu_clk);
        while (!(bus_we && bus_addr == done_addr && bus_wdata == done_mark)) begin
            @(posedge cpu_clk);
        end
        @(posedge cpu_clk);
        prog.delete();
    endtask

    task automatic finish_test(input string name);
        logic [31:0] got;
        int          errs;
        errs = 0;
        for (int n = 0; n < exp_idx.size(); n++) begin
            got = dmem[exp_idx[n]];
            if (got !== exp_val[n]) begin
                $display("** Error at %t: %s word 0x%03h read 0x%08h, expected 0x%08h",
                         $time, name, {exp_idx[n], 2'b00}, got, exp_val[n]);
                errs++;
            end
        end
        tests_run++;
        total_errs += errs;
        if (errs == 0) begin
            $display("%-12s passed, %0d words checked", name, exp_idx.size());
        end else begin
            tests_failed++;
            $display("%-12s FAILED, %0d of %0d words wrong", name, errs, exp_idx.size());
        end
        exp_idx.delete();
        exp_val.delete();
    endtask

    task automatic build_constants();
        logic [31:0] v;
        put_2ri12(addi_w, base_reg, 5'd0, 12'h100);
        for (int n = 0; n < 8; n++) begin
            v = next_rand();
            if (n == 0)
                v[11] = 1'b1;
            load_const(5'(n + 1), v);
            store_expect(5'(n + 1), 8'(n), v);
        end
        run_program();
        finish_test("constants");
    endtask

    task automatic alu_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [16:0] op;
        put_2ri12(addi_w, base_reg, 5'd0, 12'h100);
        for (int n = 0; n < 12; n++) begin
            a = next_rand();
            b = next_rand();
            op = alu_codes[n[1:0]];
            load_const(5'd1, a);
            load_const(5'd2, b);
            put_3r(op, 5'd3, 5'd1, 5'd2);
            store_expect(5'd3, 8'(n), alu_expect(op, a, b));
        end
        run_program();
        finish_test("alu");
    endtask

    // Distance 4 reads the register file and serves as the reference spacing
    task automatic forward_chain();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        logic [7:0]  slot;
        put_2ri12(addi_w, base_reg, 5'd0, 12'h100);
        for (int d = 1; d <= 4; d++) begin
            a = next_rand();
            b = next_rand();
            r3 = a + b;
            r4 = r3 - a;
            r5 = r4 | r3;
            slot = 8'(4 * (d - 1));
            load_const(5'd1, a);
            load_const(5'd2, b);
            pad(4);
            put_3r(add_w, 5'd3, 5'd1, 5'd2);
            pad(d - 1);
            put_3r(sub_w, 5'd4, 5'd3, 5'd1);
            pad(d - 1);
            put_3r(or_op, 5'd5, 5'd4, 5'd3);
            pad(d - 1);
            put_3r(and_op, 5'd6, 5'd5, 5'd4);
            store_expect(5'd3, slot, r3);
            store_expect(5'd4, slot + 8'd1, r4);
            store_expect(5'd5, slot + 8'd2, r5);
            store_expect(5'd6, slot + 8'd3, r5 & r4);
        end
        run_program();
        finish_test("forwarding");
    endtask

    task automatic load_use();
        logic [31:0] a;
        logic [31:0] b;
        logic [7:0]  scratch;
        put_2ri12(addi_w, base_reg, 5'd0, 12'h100);
        for (int n = 0; n < 2; n++) begin
            a = next_rand();
            b = next_rand();
            scratch = 8'(40 + n);
            load_const(5'd1, a);
            load_const(5'd4, b);
            store_expect(5'd1, scratch, a);
            put_2ri12(ld_w, 5'd2, base_reg, slot_off(scratch));
            put_3r(add_w, 5'd3, 5'd2, 5'd4);
            store_expect(5'd3, 8'(3 * n), a + b);
            put_2ri12(ld_w, 5'd5, base_reg, slot_off(scratch));
            store_expect(5'd5, 8'(3 * n + 1), a);
            put_2ri12(ld_w, 5'd6, base_reg, slot_off(scratch));
            put_3r(add_w, 5'd7, 5'd4, 5'd6);
            store_expect(5'd7, 8'(3 * n + 2), b + a);
        end
        run_program();
        finish_test("load-use");
    endtask

    task automatic byte_lanes();
        logic [31:0] b;
        logic [31:0] w;
        logic [31:0] v;
        logic [7:0]  bt;
        put_2ri12(addi_w, base_reg, 5'd0, 12'h100);
        // One word per lane, starting at 0x200
        for (int k = 0; k < 4; k++) begin
            b = next_rand();
            load_const(5'd1, b);
            put_2ri12(st_b, 5'd1, base_reg, 12'(256 + 5 * k));
            w = fill_word(8'(128 + k));
            w[8*k +: 8] = b[7:0];
            expect_word(8'(128 + k), w);
        end
        // Lanes 1 and 3 negative, 0 and 2 positive
        v = (next_rand() & 32'h7f7f7f7f) | 32'h80008000;
        load_const(5'd2, v);
        put_2ri12(st_w, 5'd2, base_reg, 12'h140);
        expect_word(8'd144, v);
        for (int k = 0; k < 4; k++) begin
            bt = v[8*k +: 8];
            put_2ri12(ld_b, 5'd3, base_reg, 12'(320 + k));
            store_expect(5'd3, 8'(2 * k), {{24{bt[7]}}, bt});
            put_2ri12(ld_bu, 5'd4, base_reg, 12'(320 + k));
            store_expect(5'd4, 8'(2 * k + 1), {24'h000000, bt});
        end
        run_program();
        finish_test("bytes");
    endtask

    task automatic zero_reg();
        logic [31:0] a;
        put_2ri12(addi_w, base_reg, 5'd0, 12'h100);
        a = next_rand() | 32'h0000_0001;
        load_const(5'd1, a);
        store_expect(5'd1, 8'd2, a);
        put_2ri12(addi_w, 5'd0, 5'd0, 12'h123);
        store_expect(5'd0, 8'd0, 32'h0);
        put_3r(add_w, 5'd0, 5'd1, 5'd1);
        store_expect(5'd0, 8'd1, 32'h0);
        put_2ri12(ld_w, 5'd0, base_reg, slot_off(8'd2));
        store_expect(5'd0, 8'd3, 32'h0);
        prog.push_back({lu12i_w, 20'h00000 | {12'h000, 8'hf0}, 5'd0});
        put_3r(add_w, 5'd2, 5'd0, 5'd1);
        store_expect(5'd2, 8'd4, a);
        run_program();
        finish_test("r0");
    endtask

    // Budget grows as each program is started
    initial begin
        while (watch_cycles <= cycle_budget) begin
            @(posedge cpu_clk);
            watch_cycles++;
        end
        $display("Watchdog expired after %0d cycles without the done store", watch_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        cpu_rst <= 1'b1;
        mem_load <= 1'b1;
        build_constants();
        alu_random();
        forward_chain();
        load_use();
        byte_lanes();
        zero_reg();
        $display("%0d tests run, %0d passed, %0d failed, %0d wrong words",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/cpu_top.sv
tests/tb_clock.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module cpu_tb -Mdir "$obj" -o cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$obj/cpu_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
